//--- common/mem_pkg.sv
package mem_pkg;

    // core-side access size
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    localparam logic [2:0] AXI_SIZE_BYTE = 3'b000;
    localparam logic [2:0] AXI_SIZE_HALF = 3'b001;
    localparam logic [2:0] AXI_SIZE_WORD = 3'b010;
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // one data access; wmask == 0 means load
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  wmask;
        size_e       size;
        logic [31:0] wdata;   // already in byte lanes
    } mem_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        err;
    } inst_rsp_t;

    // unit to arbiter read request
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
    } rd_req_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [2:0]  size;
    } axi_ar_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic [1:0]  resp;
    } axi_r_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

endpackage

//--- compile.f
common/mem_pkg.sv
fetch/inst_fetch_unit.sv
lsu/data_mem_unit.sv
design/axi_arbiter.sv
design/mem_subsys_top.sv
testbench/tb_clock_gen.sv
testbench/mem_subsys_properties.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- design/axi_arbiter.sv
module axi_arbiter import mem_pkg::*; #(
    parameter logic [3:0] I_ID = 4'd0,
    parameter logic [3:0] D_ID = 4'd1
) (
    input  logic    aclk,
    input  logic    i_rst_n,

    // fetch unit
    input  rd_req_t i_if_rd_req,
    input  logic    i_if_rd_valid,
    output logic    o_if_rd_ready,
    output axi_r_t  o_if_r,
    output logic    o_if_r_valid,
    input  logic    i_if_r_ready,

    // data unit
    input  rd_req_t i_dm_rd_req,
    input  logic    i_dm_rd_valid,
    output logic    o_dm_rd_ready,
    output axi_r_t  o_dm_r,
    output logic    o_dm_r_valid,
    input  logic    i_dm_r_ready,
    input  axi_aw_t i_dm_aw,
    input  logic    i_dm_aw_valid,
    output logic    o_dm_aw_ready,
    input  axi_w_t  i_dm_w,
    input  logic    i_dm_w_valid,
    output logic    o_dm_w_ready,
    output logic    o_dm_b_valid,
    input  logic    i_dm_b_ready,

    // outer bus
    output axi_ar_t    o_ar,
    output logic       o_ar_valid,
    input  logic       i_ar_ready,
    input  axi_r_t     i_r,
    input  logic       i_r_valid,
    output logic       o_r_ready,
    output axi_aw_t    o_aw,
    output logic [3:0] o_aw_id,
    output logic       o_aw_valid,
    input  logic       i_aw_ready,
    output axi_w_t     o_w,
    output logic       o_w_valid,
    input  logic       i_w_ready,
    input  logic       i_b_valid,
    output logic       o_b_ready
);

    logic    lock_q;      // pending ar not yet accepted
    logic    lock_dm_q;   // owner of that ar
    logic    grant_dm;
    rd_req_t ar_req;
    logic    r_is_dm;

    // data first unless a stalled ar holds the grant
    assign grant_dm   = lock_q ? lock_dm_q : i_dm_rd_valid;
    assign ar_req     = grant_dm ? i_dm_rd_req : i_if_rd_req;
    assign o_ar       = '{id: grant_dm ? D_ID : I_ID, addr: ar_req.addr, size: ar_req.size};
    assign o_ar_valid = grant_dm ? i_dm_rd_valid : i_if_rd_valid;

    assign o_dm_rd_ready = i_ar_ready && (lock_q ? lock_dm_q : 1'b1);
    assign o_if_rd_ready = i_ar_ready && (lock_q ? !lock_dm_q : !i_dm_rd_valid);

    always_ff @(posedge aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lock_q    <= 1'b0;
            lock_dm_q <= 1'b0;
        end else begin
            lock_q    <= o_ar_valid && !i_ar_ready;
            lock_dm_q <= grant_dm;
        end
    end

    // read beats steered by id
    assign r_is_dm      = (i_r.id == D_ID);
    assign o_if_r       = i_r;
    assign o_dm_r       = i_r;
    assign o_if_r_valid = i_r_valid && !r_is_dm;
    assign o_dm_r_valid = i_r_valid && r_is_dm;
    assign o_r_ready    = r_is_dm ? i_dm_r_ready : i_if_r_ready;

    // write side belongs to the data unit alone
    assign o_aw          = i_dm_aw;
    assign o_aw_id       = D_ID;
    assign o_aw_valid    = i_dm_aw_valid;
    assign o_dm_aw_ready = i_aw_ready;
    assign o_w           = i_dm_w;
    assign o_w_valid     = i_dm_w_valid;
    assign o_dm_w_ready  = i_w_ready;
    assign o_dm_b_valid  = i_b_valid;
    assign o_b_ready     = i_dm_b_ready;

endmodule

//--- design/mem_subsys_top.sv
module mem_subsys_top import mem_pkg::*; (
    input  logic        aclk,
    input  logic        i_rst_n,

    // instruction side
    input  logic        i_inst_en,
    input  logic [31:0] i_inst_pc,
    output logic        o_istall,
    output logic        o_inst_ok,
    output inst_rsp_t   o_inst_rsp,

    // data side
    input  logic        i_mem_en,
    input  mem_req_t    i_mem_req,
    output logic        o_dstall,
    output logic        o_data_ok,
    output logic [31:0] o_mem_rdata,

    // axi master
    output axi_ar_t     o_ar,
    output logic        o_ar_valid,
    input  logic        i_ar_ready,
    input  axi_r_t      i_r,
    input  logic        i_r_valid,
    output logic        o_r_ready,
    output axi_aw_t     o_aw,
    output logic [3:0]  o_aw_id,
    output logic        o_aw_valid,
    input  logic        i_aw_ready,
    output axi_w_t      o_w,
    output logic        o_w_valid,
    input  logic        i_w_ready,
    input  logic        i_b_valid,
    output logic        o_b_ready
);

    rd_req_t if_rd_req, dm_rd_req;
    logic    if_rd_valid, if_rd_ready, dm_rd_valid, dm_rd_ready;
    axi_r_t  if_r, dm_r;
    logic    if_r_valid, if_r_ready, dm_r_valid, dm_r_ready;
    axi_aw_t dm_aw;
    axi_w_t  dm_w;
    logic    dm_aw_valid, dm_aw_ready, dm_w_valid, dm_w_ready;
    logic    dm_b_valid, dm_b_ready;

    inst_fetch_unit inst_fetch_unit_inst (
        .aclk       (aclk),         .i_rst_n    (i_rst_n),
        .i_inst_en  (i_inst_en),    .i_inst_pc  (i_inst_pc),
        .o_istall   (o_istall),     .o_inst_ok  (o_inst_ok),
        .o_inst_rsp (o_inst_rsp),
        .o_rd_req   (if_rd_req),    .o_rd_valid (if_rd_valid),
        .i_rd_ready (if_rd_ready),
        .i_r        (if_r),         .i_r_valid  (if_r_valid),
        .o_r_ready  (if_r_ready)
    );

    data_mem_unit data_mem_unit_inst (
        .aclk        (aclk),        .i_rst_n     (i_rst_n),
        .i_mem_en    (i_mem_en),    .i_mem_req   (i_mem_req),
        .o_dstall    (o_dstall),    .o_data_ok   (o_data_ok),
        .o_mem_rdata (o_mem_rdata),
        .o_rd_req    (dm_rd_req),   .o_rd_valid  (dm_rd_valid),
        .i_rd_ready  (dm_rd_ready),
        .i_r         (dm_r),        .i_r_valid   (dm_r_valid),
        .o_r_ready   (dm_r_ready),
        .o_aw        (dm_aw),       .o_aw_valid  (dm_aw_valid),
        .i_aw_ready  (dm_aw_ready),
        .o_w         (dm_w),        .o_w_valid   (dm_w_valid),
        .i_w_ready   (dm_w_ready),
        .i_b_valid   (dm_b_valid),  .o_b_ready   (dm_b_ready)
    );

    axi_arbiter #(
        .I_ID (4'd0),   // fetch
        .D_ID (4'd1)
    ) axi_arbiter_inst (
        .aclk          (aclk),          .i_rst_n       (i_rst_n),
        .i_if_rd_req   (if_rd_req),     .i_if_rd_valid (if_rd_valid),
        .o_if_rd_ready (if_rd_ready),
        .o_if_r        (if_r),          .o_if_r_valid  (if_r_valid),
        .i_if_r_ready  (if_r_ready),
        .i_dm_rd_req   (dm_rd_req),     .i_dm_rd_valid (dm_rd_valid),
        .o_dm_rd_ready (dm_rd_ready),
        .o_dm_r        (dm_r),          .o_dm_r_valid  (dm_r_valid),
        .i_dm_r_ready  (dm_r_ready),
        .i_dm_aw       (dm_aw),         .i_dm_aw_valid (dm_aw_valid),
        .o_dm_aw_ready (dm_aw_ready),
        .i_dm_w        (dm_w),          .i_dm_w_valid  (dm_w_valid),
        .o_dm_w_ready  (dm_w_ready),
        .o_dm_b_valid  (dm_b_valid),    .i_dm_b_ready  (dm_b_ready),
        .o_ar          (o_ar),          .o_ar_valid    (o_ar_valid),
        .i_ar_ready    (i_ar_ready),
        .i_r           (i_r),           .i_r_valid     (i_r_valid),
        .o_r_ready     (o_r_ready),
        .o_aw          (o_aw),          .o_aw_id       (o_aw_id),
        .o_aw_valid    (o_aw_valid),    .i_aw_ready    (i_aw_ready),
        .o_w           (o_w),           .o_w_valid     (o_w_valid),
        .i_w_ready     (i_w_ready),
        .i_b_valid     (i_b_valid),     .o_b_ready     (o_b_ready)
    );

endmodule

//--- fetch/inst_fetch_unit.sv
module inst_fetch_unit import mem_pkg::*; (
    input  logic      aclk,
    input  logic      i_rst_n,

    input  logic        i_inst_en,
    input  logic [31:0] i_inst_pc,
    output logic        o_istall,
    output logic        o_inst_ok,
    output inst_rsp_t   o_inst_rsp,

    output rd_req_t   o_rd_req,
    output logic      o_rd_valid,
    input  logic      i_rd_ready,

    input  axi_r_t    i_r,
    input  logic      i_r_valid,
    output logic      o_r_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_WAIT
    } fetch_state_e;

    fetch_state_e state;

    assign o_istall   = i_inst_en && !o_inst_ok;
    assign o_rd_valid = (state == ST_ADDR);
    assign o_r_ready  = (state == ST_WAIT);

    always_ff @(posedge aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= ST_IDLE;
            o_inst_ok <= 1'b0;
        end else begin
            o_inst_ok <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // skip the ok cycle, request there is the old one
                    if (i_inst_en && !o_inst_ok) begin
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (i_rd_ready) state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (i_r_valid) begin
                        state     <= ST_IDLE;
                        o_inst_ok <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request and result payload
    always_ff @(posedge aclk) begin
        if (state == ST_IDLE && i_inst_en && !o_inst_ok) begin
            o_rd_req.addr <= i_inst_pc;
            o_rd_req.size <= AXI_SIZE_WORD;   // fetch is always a word
        end
        if (state == ST_WAIT && i_r_valid) begin
            o_inst_rsp.data <= i_r.data;
            o_inst_rsp.err  <= (i_r.resp != AXI_RESP_OKAY);
        end
    end

endmodule

//--- lsu/data_mem_unit.sv
module data_mem_unit import mem_pkg::*; (
    input  logic        aclk,
    input  logic        i_rst_n,

    input  logic        i_mem_en,
    input  mem_req_t    i_mem_req,
    output logic        o_dstall,
    output logic        o_data_ok,
    output logic [31:0] o_mem_rdata,

    output rd_req_t     o_rd_req,
    output logic        o_rd_valid,
    input  logic        i_rd_ready,
    input  axi_r_t      i_r,
    input  logic        i_r_valid,
    output logic        o_r_ready,

    output axi_aw_t     o_aw,
    output logic        o_aw_valid,
    input  logic        i_aw_ready,
    output axi_w_t      o_w,
    output logic        o_w_valid,
    input  logic        i_w_ready,
    input  logic        i_b_valid,
    output logic        o_b_ready
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_ADDR,
        ST_RD_WAIT,
        ST_WR,
        ST_WR_RESP
    } dmem_state_e;

    dmem_state_e state;
    mem_req_t    req_q;
    logic        aw_pend;
    logic        w_pend;
    logic [2:0]  axi_size;
    logic [31:0] shifted;
    logic [31:0] load_data;
    logic        start;

    assign start    = (state == ST_IDLE) && i_mem_en && !o_data_ok;
    assign o_dstall = i_mem_en && !o_data_ok;

    always_comb begin
        case (req_q.size)
            SIZE_BYTE: axi_size = AXI_SIZE_BYTE;
            SIZE_HALF: axi_size = AXI_SIZE_HALF;
            default:   axi_size = AXI_SIZE_WORD;
        endcase
    end

    assign o_rd_req   = '{addr: req_q.addr, size: axi_size};
    assign o_aw       = '{addr: req_q.addr, size: axi_size};
    assign o_w        = '{data: req_q.wdata, strb: req_q.wmask};
    assign o_rd_valid = (state == ST_RD_ADDR);
    assign o_r_ready  = (state == ST_RD_WAIT);
    assign o_aw_valid = (state == ST_WR) && aw_pend;
    assign o_w_valid  = (state == ST_WR) && w_pend;
    assign o_b_ready  = (state == ST_WR_RESP);

    // addressed lanes down to bit 0, then zero-extend
    always_comb begin
        shifted = i_r.data >> {req_q.addr[1:0], 3'b000};
        case (req_q.size)
            SIZE_BYTE: load_data = {24'b0, shifted[7:0]};
            SIZE_HALF: load_data = {16'b0, shifted[15:0]};
            default:   load_data = shifted;
        endcase
    end

    always_ff @(posedge aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= ST_IDLE;
            o_data_ok <= 1'b0;
            aw_pend   <= 1'b0;
            w_pend    <= 1'b0;
        end else begin
            o_data_ok <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        if (|i_mem_req.wmask) begin
                            state   <= ST_WR;
                            aw_pend <= 1'b1;
                            w_pend  <= 1'b1;
                        end else begin
                            state <= ST_RD_ADDR;
                        end
                    end
                end
                ST_RD_ADDR: if (i_rd_ready) state <= ST_RD_WAIT;
                ST_RD_WAIT: begin
                    if (i_r_valid) begin
                        state     <= ST_IDLE;
                        o_data_ok <= 1'b1;
                    end
                end
                ST_WR: begin
                    // aw and w finish in any order
                    if (i_aw_ready) aw_pend <= 1'b0;
                    if (i_w_ready) w_pend <= 1'b0;
                    if ((!aw_pend || i_aw_ready) && (!w_pend || i_w_ready)) begin
                        state <= ST_WR_RESP;
                    end
                end
                ST_WR_RESP: begin
                    if (i_b_valid) begin
                        state     <= ST_IDLE;
                        o_data_ok <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (start) req_q <= i_mem_req;
        if (state == ST_RD_WAIT && i_r_valid) o_mem_rdata <= load_data;
    end

endmodule

//--- testbench/mem_subsys_properties.sv
module mem_subsys_properties import mem_pkg::*; (
    input logic    aclk,
    input logic    i_rst_n,
    input logic    i_inst_ok,
    input logic    i_data_ok,
    input axi_ar_t i_ar,
    input logic    i_ar_valid,
    input logic    i_ar_ready,
    input axi_aw_t i_aw,
    input logic    i_aw_valid,
    input logic    i_aw_ready,
    input axi_w_t  i_w,
    input logic    i_w_valid,
    input logic    i_w_ready
);

    int fail_count = 0;

    ar_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
        i_ar_valid && !i_ar_ready |=> i_ar_valid && $stable(i_ar))
        else begin
            $error("ar dropped or changed before ready");
            fail_count++;
        end

    aw_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
        i_aw_valid && !i_aw_ready |=> i_aw_valid && $stable(i_aw))
        else begin
            $error("aw dropped or changed before ready");
            fail_count++;
        end

    w_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
        i_w_valid && !i_w_ready |=> i_w_valid && $stable(i_w))
        else begin
            $error("w dropped or changed before ready");
            fail_count++;
        end

    // nothing may leave the block while reset is low
    quiet_in_reset: assert property (@(posedge aclk)
        !i_rst_n |-> !i_ar_valid && !i_aw_valid && !i_w_valid && !i_inst_ok && !i_data_ok)
        else begin
            $error("valid or ok high during reset");
            fail_count++;
        end

    inst_ok_pulse: assert property (@(posedge aclk) disable iff (!i_rst_n)
        i_inst_ok |=> !i_inst_ok)
        else begin
            $error("inst ok longer than one cycle");
            fail_count++;
        end

    data_ok_pulse: assert property (@(posedge aclk) disable iff (!i_rst_n)
        i_data_ok |=> !i_data_ok)
        else begin
            $error("data ok longer than one cycle");
            fail_count++;
        end

endmodule

//--- testbench/tb_checker.sv
module tb_checker import mem_pkg::*; #(
    parameter logic [31:0] MEM_SALT = 32'h0
) (
    input  logic        aclk,
    input  logic        i_rst_n,
    input  logic        i_inst_en,
    input  logic [31:0] i_inst_pc,
    input  logic        i_istall,
    input  logic        i_inst_ok,
    input  inst_rsp_t   i_inst_rsp,
    input  logic        i_mem_en,
    input  mem_req_t    i_mem_req,
    input  logic        i_dstall,
    input  logic        i_data_ok,
    input  logic [31:0] i_mem_rdata,
    input  axi_ar_t     i_ar,
    input  logic        i_ar_valid,
    input  logic        i_ar_ready,
    input  axi_aw_t     i_aw,
    input  logic [3:0]  i_aw_id,
    input  logic        i_aw_valid,
    input  logic        i_aw_ready,
    output int          o_checks,
    output int          o_errors
);

    logic [31:0] shadow [logic [29:0]];
    logic        fetch_pend = 1'b0;
    logic        data_pend = 1'b0;
    logic [31:0] fetch_pc;
    mem_req_t    data_req;

    initial begin
        o_checks = 0;
        o_errors = 0;
    end

    function automatic logic [31:0] shadow_read(input logic [31:0] addr);
        if (shadow.exists(addr[31:2])) return shadow[addr[31:2]];
        return {addr[31:2], 2'b00} ^ MEM_SALT;   // untouched word
    endfunction

    function automatic logic [31:0] expected_load(input mem_req_t req);
        logic [31:0] lanes;
        lanes = shadow_read(req.addr) >> (8 * req.addr[1:0]);
        case (req.size)
            SIZE_BYTE: return lanes & 32'h0000_00ff;
            SIZE_HALF: return lanes & 32'h0000_ffff;
            default:   return lanes;
        endcase
    endfunction

    // axi size field is log2 of the byte count
    function automatic logic [2:0] axi_size_of(input size_e size);
        case (size)
            SIZE_BYTE: return 3'd0;
            SIZE_HALF: return 3'd1;
            default:   return 3'd2;
        endcase
    endfunction

    task automatic store_to_shadow(input mem_req_t req);
        logic [31:0] word;
        word = shadow_read(req.addr);
        for (int b = 0; b < 4; b++) begin
            if (req.wmask[b]) word[8*b +: 8] = req.wdata[8*b +: 8];
        end
        shadow[req.addr[31:2]] = word;
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        o_checks++;
        if (got !== exp) begin
            o_errors++;
            $display("[FAIL] %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic protocol_error(input string what);
        o_errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    always @(posedge aclk) begin
        if (!i_rst_n) begin
            fetch_pend = 1'b0;
            data_pend  = 1'b0;
        end else begin
            // stall covers every outstanding request up to its ok
            compare("o_istall", i_istall, (fetch_pend || i_inst_en) && !i_inst_ok);
            compare("o_dstall", i_dstall, (data_pend || i_mem_en) && !i_data_ok);
            // id tells who owns the address
            if (i_ar_valid && i_ar_ready) begin
                if (i_ar.id == 4'd0 && fetch_pend) begin
                    compare("o_ar.addr", i_ar.addr, fetch_pc);
                    compare("o_ar.size", i_ar.size, 3'd2);
                end else if (i_ar.id == 4'd1 && data_pend && !(|data_req.wmask)) begin
                    compare("o_ar.addr", i_ar.addr, data_req.addr);
                    compare("o_ar.size", i_ar.size, axi_size_of(data_req.size));
                end else begin
                    protocol_error("read address with a wrong id or no matching request");
                end
            end
            if (i_aw_valid && i_aw_ready) begin
                if (data_pend && |data_req.wmask) begin
                    compare("o_aw_id", i_aw_id, 4'd1);
                    compare("o_aw.addr", i_aw.addr, data_req.addr);
                end else begin
                    protocol_error("write address with no store pending");
                end
            end
            if (i_inst_ok) begin
                if (fetch_pend) begin
                    compare("o_inst_rsp.data", i_inst_rsp.data, shadow_read(fetch_pc));
                    compare("o_inst_rsp.err", i_inst_rsp.err, fetch_pc[31:28] == 4'hf);
                end else begin
                    protocol_error("o_inst_ok pulsed with no fetch pending");
                end
                fetch_pend = 1'b0;
            end else if (i_inst_en && !fetch_pend) begin
                fetch_pend = 1'b1;
                fetch_pc   = i_inst_pc;
            end
            if (i_data_ok) begin
                if (!data_pend) begin
                    protocol_error("o_data_ok pulsed with no access pending");
                end else if (|data_req.wmask) begin
                    store_to_shadow(data_req);
                end else begin
                    compare("o_mem_rdata", i_mem_rdata, expected_load(data_req));
                end
                data_pend = 1'b0;
            end else if (i_mem_en && !data_pend) begin
                data_pend = 1'b1;
                data_req  = i_mem_req;
            end
        end
    end

endmodule

//--- testbench/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD = 10
) (
    output logic o_clk
);

    initial o_clk = 1'b0;

    always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

//--- testbench/tb_top.sv
module tb_top import mem_pkg::*; ();

    localparam int          N_INST   = 150;
    localparam int          N_DATA   = 150;
    localparam logic [31:0] MEM_SALT = 32'h5a3c_96e1;

    logic        aclk;
    logic        rst_n;
    int          seed = 45;
    int          inst_seed;
    int          data_seed;
    int          slave_seed;
    int          checks;
    int          chk_errors;

    logic        inst_en = 1'b0;
    logic [31:0] inst_pc = '0;
    logic        istall;
    logic        inst_ok;
    inst_rsp_t   inst_rsp;
    logic        mem_en = 1'b0;
    mem_req_t    mem_req = '0;
    logic        dstall;
    logic        data_ok;
    logic [31:0] mem_rdata;

    axi_ar_t     ar;
    logic        ar_valid;
    logic        ar_ready = 1'b0;
    axi_r_t      r = '0;
    logic        r_valid = 1'b0;
    logic        r_ready;
    axi_aw_t     aw;
    logic [3:0]  aw_id;
    logic        aw_valid;
    logic        aw_ready = 1'b0;
    axi_w_t      w;
    logic        w_valid;
    logic        w_ready = 1'b0;
    logic        b_valid = 1'b0;
    logic        b_ready;

    // slave memory state
    logic [31:0] mem [logic [29:0]];
    axi_ar_t     rd_q [$];
    axi_aw_t     aw_q;
    axi_w_t      w_q;
    logic        r_fire = 1'b0;
    logic        b_fire = 1'b0;
    logic        got_aw = 1'b0;
    logic        got_w = 1'b0;

    tb_clock_gen #(.PERIOD(10)) tb_clock_gen_inst (.o_clk(aclk));

    mem_subsys_top mem_subsys_top_inst (
        .aclk        (aclk),        .i_rst_n     (rst_n),
        .i_inst_en   (inst_en),     .i_inst_pc   (inst_pc),
        .o_istall    (istall),      .o_inst_ok   (inst_ok),
        .o_inst_rsp  (inst_rsp),
        .i_mem_en    (mem_en),      .i_mem_req   (mem_req),
        .o_dstall    (dstall),      .o_data_ok   (data_ok),
        .o_mem_rdata (mem_rdata),
        .o_ar        (ar),          .o_ar_valid  (ar_valid),
        .i_ar_ready  (ar_ready),
        .i_r         (r),           .i_r_valid   (r_valid),
        .o_r_ready   (r_ready),
        .o_aw        (aw),          .o_aw_id     (aw_id),
        .o_aw_valid  (aw_valid),    .i_aw_ready  (aw_ready),
        .o_w         (w),           .o_w_valid   (w_valid),
        .i_w_ready   (w_ready),
        .i_b_valid   (b_valid),     .o_b_ready   (b_ready)
    );

    tb_checker #(.MEM_SALT(MEM_SALT)) tb_checker_inst (
        .aclk        (aclk),        .i_rst_n     (rst_n),
        .i_inst_en   (inst_en),     .i_inst_pc   (inst_pc),
        .i_istall    (istall),
        .i_inst_ok   (inst_ok),     .i_inst_rsp  (inst_rsp),
        .i_mem_en    (mem_en),      .i_mem_req   (mem_req),
        .i_dstall    (dstall),
        .i_data_ok   (data_ok),     .i_mem_rdata (mem_rdata),
        .i_ar        (ar),          .i_ar_valid  (ar_valid),
        .i_ar_ready  (ar_ready),
        .i_aw        (aw),          .i_aw_id     (aw_id),
        .i_aw_valid  (aw_valid),    .i_aw_ready  (aw_ready),
        .o_checks    (checks),      .o_errors    (chk_errors)
    );

    bind mem_subsys_top mem_subsys_properties mem_subsys_properties_inst (
        .aclk       (aclk),         .i_rst_n    (i_rst_n),
        .i_inst_ok  (o_inst_ok),
        .i_data_ok  (o_data_ok),
        .i_ar       (o_ar),         .i_ar_valid (o_ar_valid),
        .i_ar_ready (i_ar_ready),
        .i_aw       (o_aw),         .i_aw_valid (o_aw_valid),
        .i_aw_ready (i_aw_ready),
        .i_w        (o_w),          .i_w_valid  (o_w_valid),
        .i_w_ready  (i_w_ready)
    );

    function automatic logic [31:0] slave_read(input logic [31:0] addr);
        if (mem.exists(addr[31:2])) return mem[addr[31:2]];
        return {addr[31:2], 2'b00} ^ MEM_SALT;
    endfunction

    // handshakes seen at the rising edge
    always @(posedge aclk) begin
        if (rst_n) begin
            if (ar_valid && ar_ready) rd_q.push_back(ar);
            if (r_valid && r_ready) r_fire = 1'b1;
            if (aw_valid && aw_ready) begin
                aw_q   = aw;
                got_aw = 1'b1;
            end
            if (w_valid && w_ready) begin
                w_q   = w;
                got_w = 1'b1;
            end
            if (b_valid && b_ready) b_fire = 1'b1;
        end
    end

    always @(negedge aclk) begin : slave_drive
        logic [31:0] rnd;
        logic [31:0] word;
        int          idx;
        if (!rst_n) begin
            ar_ready = 1'b0;
            aw_ready = 1'b0;
            w_ready  = 1'b0;
            r_valid  = 1'b0;
            b_valid  = 1'b0;
            rd_q.delete();
            r_fire = 1'b0;
            b_fire = 1'b0;
            got_aw = 1'b0;
            got_w  = 1'b0;
        end else begin
            rnd      = $random(slave_seed);
            ar_ready = rnd[1:0] != 2'b00;
            aw_ready = rnd[3:2] != 2'b00;
            w_ready  = rnd[5:4] != 2'b00;
            if (r_fire) begin
                r_valid = 1'b0;
                r_fire  = 1'b0;
            end
            if (!r_valid && rd_q.size() != 0 && rnd[7:6] != 2'b00) begin
                // sometimes answer the younger read first
                idx    = (rd_q.size() > 1 && rnd[8]) ? 1 : 0;
                r.id   = rd_q[idx].id;
                r.data = slave_read(rd_q[idx].addr);
                r.resp = (rd_q[idx].addr[31:28] == 4'hf) ? 2'b10 : 2'b00;   // slverr
                rd_q.delete(idx);
                r_valid = 1'b1;
            end
            if (b_fire) begin
                b_valid = 1'b0;
                b_fire  = 1'b0;
            end
            if (got_aw && got_w && !b_valid && rnd[9]) begin
                word = slave_read(aw_q.addr);
                for (int b = 0; b < 4; b++) begin
                    if (w_q.strb[b]) word[8*b +: 8] = w_q.data[8*b +: 8];
                end
                mem[aw_q.addr[31:2]] = word;
                got_aw  = 1'b0;
                got_w   = 1'b0;
                b_valid = 1'b1;
            end
        end
    end

    task automatic run_fetches();
        logic [31:0] rnd;
        for (int n = 0; n < N_INST; n++) begin
            rnd = $random(inst_seed);
            if (rnd[1:0] != 2'b00) begin
                inst_en = 1'b0;
                repeat (rnd[1:0]) @(negedge aclk);
            end
            inst_en = 1'b1;
            // one fetch in eight lands in the error region
            if (rnd[31:29] == 3'b000) inst_pc = {4'hf, 18'h0, rnd[11:4], 2'b00};
            else inst_pc = {22'h0, rnd[11:4], 2'b00};
            do @(negedge aclk); while (!inst_ok);
        end
        inst_en = 1'b0;
    endtask

    task automatic run_data();
        logic [31:0] rnd;
        logic [31:0] wd;
        logic [1:0]  low;
        mem_req_t    req;
        for (int n = 0; n < N_DATA; n++) begin
            rnd = $random(data_seed);
            wd  = $random(data_seed);
            if (rnd[19:18] != 2'b00) begin
                mem_en = 1'b0;
                repeat (rnd[19:18]) @(negedge aclk);
            end
            case (rnd[11:10])
                2'd0: begin
                    req.size = SIZE_BYTE;
                    low      = rnd[9:8];
                end
                2'd1: begin
                    req.size = SIZE_HALF;
                    low      = {rnd[9], 1'b0};
                end
                default: begin
                    req.size = SIZE_WORD;
                    low      = 2'b00;
                end
            endcase
            req.wmask = 4'h0;
            req.wdata = '0;
            if (rnd[12]) begin
                req.size  = SIZE_WORD;
                low       = 2'b00;
                req.wmask = (rnd[17:14] == 4'h0) ? 4'hf : rnd[17:14];
                req.wdata = wd;
            end
            req.addr = {16'h0001, 10'h000, rnd[7:4], low};   // 16 words, many hits
            mem_en   = 1'b1;
            mem_req  = req;
            do @(negedge aclk); while (!data_ok);
        end
        mem_en = 1'b0;
    endtask

    function automatic int total_errors();
        return chk_errors + mem_subsys_top_inst.mem_subsys_properties_inst.fail_count;
    endfunction

    task automatic print_summary();
        $display("checks %0d, checker errors %0d, assertion failures %0d",
                 checks, chk_errors, mem_subsys_top_inst.mem_subsys_properties_inst.fail_count);
    endtask

    initial begin
        inst_seed  = seed;
        data_seed  = seed + 1;
        slave_seed = seed + 2;
        rst_n = 1'b1;
        #1 rst_n = 1'b0;
        repeat (8) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        fork
            run_fetches();
            run_data();
        join
        repeat (5) @(negedge aclk);
        print_summary();
        if (total_errors() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat ((N_INST + N_DATA) * 40) @(posedge aclk);
        $display("timeout: requests still outstanding after %0d cycles", (N_INST + N_DATA) * 40);
        print_summary();
        $display("sim failed");
        $finish;
    end

endmodule
